/* tb.f */
rtl/mcuPkg.sv
rtl/mcuRegs.sv
rtl/linkRx.sv
rtl/linkTx.sv
rtl/coincMatch.sv
rtl/mcuTop.sv
verification/mcuTb.sv

/* verification/mcuTb.sv */
// self-checking testbench for the two-link coincidence unit
// drives random link words and wishbone cycles, a model built from the link timing
// rules predicts bad-idle counters, register reads and every output code

module mcuTb;
   import mcuPkg::*;

   localparam logic [WbDatW-1:0] DevId = 16'h1234;
   localparam int NumRegOps  = 24;
   localparam int StreamLen  = 600;
   localparam int NumPairs   = 40;
   localparam int PlanCycles = 60 + NumRegOps * 14 + 100 + StreamLen + 30 + NumPairs * 19 + 30;
   localparam int MaxCycles  = 2 * PlanCycles;

   logic                clk;
   logic                rst;
   wbReq_t              wbIn;
   wbRsp_t              wbOut;
   logic [LinkInW-1:0]  linkInA, linkInB;
   logic [LinkOutW-1:0] linkOutA, linkOutB;

   int                  edgeCnt;        // rising edges so far
   bit                  running;        // link words driven and modelled
   bit                  checkOn;        // output codes compared
   bit                  noisy;          // random triggers and corruptions
   bit                  busBusy;        // ack allowed
   logic [15:0]         grpCount [2];   // count carried by the group being sent
   int                  idlePos [2];    // next idle word of the group
   int                  cool [2];       // keeps random triggers apart on one link
   logic [LinkInW-1:0]  prevWord [2];
   logic [11:0]         nibbles [2];    // received low nibbles of the group
   logic [15:0]         storedCnt [2];
   int                  badCnt [2];
   int                  txPhase [2];    // idle word expected next on linkOut
   int                  trigOff [int];  // key 2*edge+link, offset of a sampled trigger
   int                  injOff [int];   // triggers to place, same key
   logic [LinkOutW-1:0] forced [int];   // answer and special codes, same key
   logic [15:0]         spWordM;
   logic [LinkOutW-1:0] testPattM;
   logic [1:0]          testEnM;
   logic [DiffW-1:0]    diffMaxM;

   mcuTop #(.DeviceId(DevId)) UUT (
      .clk(clk),
      .rst(rst),
      .wbIn(wbIn),
      .wbOut(wbOut),
      .linkInA(linkInA),
      .linkInB(linkInB),
      .linkOutA(linkOutA),
      .linkOutB(linkOutB)
   );

   always #4 clk = ~clk;

   task automatic reportError(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1);
   endtask

   function automatic logic [LinkOutW-1:0] idleCode(input int p);
      case (p)
         0:       return KIdle0;
         1:       return KIdle1;
         2:       return KIdle2;
         default: return KIdle3;
      endcase
   endfunction

   // idle p carries count nibble p in bits 5..4 and 1..0
   function automatic logic [LinkInW-1:0] idleWord(input int p, input logic [15:0] cnt);
      logic [3:0] nib;
      nib = cnt[4*p +: 4];
      return Idle0In | LinkInW'(p << 2) | {2'b00, nib[3:2], 2'b00, nib[1:0]};
   endfunction

   function automatic int idleType(input logic [LinkInW-1:0] w);
      case (w & IdleMask)
         Idle0In: return 0;
         Idle1In: return 1;
         Idle2In: return 2;
         Idle3In: return 3;
         default: return -1;  // trigger or junk
      endcase
   endfunction

   function automatic logic [WbDatW-1:0] expectedRead(input logic [WbAdrW-1:0] adr);
      case (adr)
         AdrId:       return DevId;
         AdrSpWord:   return spWordM;
         AdrTestPatt: return WbDatW'(testPattM);
         AdrTestEn:   return WbDatW'(testEnM);
         AdrDiffMax:  return WbDatW'(diffMaxM);
         AdrBadIdleA: return WbDatW'(badCnt[0]);
         AdrBadIdleB: return WbDatW'(badCnt[1]);
         default:     return '0;
      endcase
   endfunction

   function automatic bit isMapped(input logic [WbAdrW-1:0] adr);
      return adr inside {AdrId, AdrSpWord, AdrTestPatt, AdrTestEn, AdrDiffMax,
                         AdrBadIdleA, AdrBadIdleB};
   endfunction

   // bad-idle rules for one sampled word
   task automatic scoreWord(input int l, input logic [LinkInW-1:0] w);
      int          typ;
      int          prevTyp;
      logic [3:0]  nib;
      logic [15:0] full;
      typ     = idleType(w);
      prevTyp = idleType(prevWord[l]);
      nib     = {w[5:4], w[1:0]};
      if (typ < 0) begin
         if ((w & TrigMask) == '0) badCnt[l]++;  // neither trigger nor idle
      end else if (typ == 0) begin
         if (prevTyp >= 0 && prevTyp != 3) badCnt[l]++;
         nibbles[l][3:0] = nib;
      end else begin
         if (prevTyp != typ - 1) badCnt[l]++;
         if (typ == 3) begin
            full = {nib, nibbles[l]};
            if (full != storedCnt[l] + 16'd1) badCnt[l]++;  // group count must step by one
            storedCnt[l] = full;
         end else begin
            nibbles[l][4*typ +: 4] = nib;
         end
      end
      prevWord[l] = w;
   endtask

   task automatic advance(input int l);
      idlePos[l]++;
      if (idlePos[l] == 4) begin
         idlePos[l] = 0;
         grpCount[l]++;
      end
   endtask

   // next word of link l, sampled on the coming edge
   task automatic linkWord(input int l, output logic [LinkInW-1:0] w);
      int                        key;
      logic signed [OffsetW-1:0] off;
      logic                      lsb;
      key = 2 * (edgeCnt + 1) + l;
      lsb = $urandom_range(1);
      if (injOff.exists(key) || (noisy && cool[l] == 0 && $urandom_range(9) == 0)) begin
         off = injOff.exists(key) ? OffsetW'(injOff[key]) : OffsetW'($urandom);
         w = {1'b1, off, lsb};  // inserted, the idle stream pauses
         trigOff[key] = off;
         cool[l] = 4;
      end else if (noisy && $urandom_range(11) == 0) begin
         case ($urandom_range(3))
            0: begin
               w = LinkInW'($urandom_range(63));  // bit 6 clear, never an idle
               advance(l);
            end
            1: begin
               advance(l);  // one idle word dropped
               w = idleWord(idlePos[l], grpCount[l]);
               advance(l);
            end
            2: begin
               w = idleWord(idlePos[l], grpCount[l]);  // sent again next cycle
            end
            default: begin
               grpCount[l] += 16'd2;  // count jumps mid group
               w = idleWord(idlePos[l], grpCount[l]);
               advance(l);
            end
         endcase
      end else begin
         w = idleWord(idlePos[l], grpCount[l]);
         advance(l);
      end
      if (cool[l] > 0) cool[l]--;
      scoreWord(l, w);
   endtask

   // window rule for a trigger of link l sampled at edge k, answer code five edges later
   task automatic judgeTrig(input int l, input int k);
      int own;
      int diff;
      bit hit;
      if (trigOff.exists(2 * k + l)) begin
         own = trigOff[2 * k + l];
         hit = 0;
         for (int d = -1; d <= 1; d++) begin
            if (trigOff.exists(2 * (k + d) + 1 - l)) begin
               diff = trigOff[2 * (k + d) + 1 - l] - own + CycleUnits * d;
               if (diff < 0) diff = -diff;
               if (diff <= int'(diffMaxM)) hit = 1;
            end
         end
         forced[2 * (k + 5) + l] = hit ? KPromptCoinc : KNoCoinc;
      end
   endtask

   task automatic checkLinks();
      logic [LinkOutW-1:0] got;
      logic [LinkOutW-1:0] exp;
      int                  key;
      for (int l = 0; l < 2; l++) begin
         key = 2 * edgeCnt + l;
         got = (l == 0) ? linkOutA : linkOutB;
         if (forced.exists(key)) begin
            exp = forced[key];
            txPhase[l] = 0;  // idles restart at Idle0
         end else begin
            exp = idleCode(txPhase[l]);
            txPhase[l] = (txPhase[l] + 1) % 4;
         end
         if (testEnM[l]) exp = testPattM;
         assert (got == exp) else
            reportError($sformatf("[FAIL] linkOut%s exp %h got %h at cycle %0d",
                                  (l == 0) ? "A" : "B", exp, got, edgeCnt));
      end
   endtask

   task automatic nextCycle();
      logic [LinkInW-1:0] wA;
      logic [LinkInW-1:0] wB;
      @(posedge clk);
      #1;
      edgeCnt++;
      assert (edgeCnt <= MaxCycles) else
         reportError($sformatf("timeout, run went past %0d cycles", MaxCycles));
      if (!busBusy) begin
         assert (!wbOut.ack) else reportError("ack raised with no bus request");
      end
      if (running) begin
         if (checkOn) checkLinks();
         linkWord(0, wA);
         linkWord(1, wB);
         linkInA = wA;
         linkInB = wB;
         judgeTrig(0, edgeCnt);
         judgeTrig(1, edgeCnt);
      end
   endtask

   task automatic idleCycles(input int n);
      repeat (n) nextCycle();
   endtask

   // register model, a write lands on the ack edge
   task automatic modelWrite(input logic [WbAdrW-1:0] adr, input logic [WbDatW-1:0] dat);
      case (adr)
         AdrSpWord: begin
            spWordM = dat;
            for (int l = 0; l < 2; l++) begin
               forced[2 * (edgeCnt + 3) + l] = KSpecial;
               for (int i = 0; i < 4; i++) begin
                  forced[2 * (edgeCnt + 4 + i) + l] = dat[4 * (3 - i) +: 4];  // high first
               end
            end
         end
         AdrTestPatt: testPattM = dat[LinkOutW-1:0];
         AdrTestEn:   testEnM = dat[1:0];
         AdrDiffMax:  diffMaxM = dat[DiffW-1:0];
         default: ;
      endcase
   endtask

   task automatic wbTransfer(input logic we, input logic [WbAdrW-1:0] adr,
                             input logic [WbDatW-1:0] dat, output logic [WbDatW-1:0] rd);
      int waited;
      busBusy = 1;
      wbIn.cyc = 1'b1;
      wbIn.stb = 1'b1;
      wbIn.we  = we;
      wbIn.adr = adr;
      wbIn.dat = dat;
      waited = 0;
      do begin
         nextCycle();
         waited++;
      end while (!wbOut.ack && waited < 10);
      assert (wbOut.ack) else reportError($sformatf("no ack for address %h", adr));
      rd = wbOut.dat;
      if (we) modelWrite(adr, dat);
      wbIn.cyc = 1'b0;
      wbIn.stb = 1'b0;
      wbIn.we  = 1'b0;
      nextCycle();
      assert (!wbOut.ack) else reportError($sformatf("ack held too long at address %h", adr));
      busBusy = 0;
   endtask

   task automatic regWrite(input logic [WbAdrW-1:0] adr, input logic [WbDatW-1:0] dat);
      logic [WbDatW-1:0] rd;
      wbTransfer(1'b1, adr, dat, rd);
   endtask

   task automatic checkRead(input logic [WbAdrW-1:0] adr);
      logic [WbDatW-1:0] rd;
      logic [WbDatW-1:0] exp;
      wbTransfer(1'b0, adr, '0, rd);
      exp = expectedRead(adr);
      assert (rd == exp) else
         reportError($sformatf("[FAIL] wbOut.dat at address %h exp %h got %h", adr, exp, rd));
   endtask

   initial begin
      logic [WbAdrW-1:0] adr;
      int                sel;
      int                d;
      void'($urandom(99));
      clk = 1'b0;
      rst = 1'b1;
      wbIn = '0;
      linkInA = '0;
      linkInB = '0;
      edgeCnt = 0;
      running = 0;
      checkOn = 0;
      noisy = 0;
      busBusy = 0;
      for (int l = 0; l < 2; l++) begin
         grpCount[l] = 16'd1;  // first group follows stored count zero
         idlePos[l] = 0;
         cool[l] = 0;
         prevWord[l] = '0;
         nibbles[l] = '0;
         storedCnt[l] = '0;
         badCnt[l] = 0;
         txPhase[l] = 0;
      end
      spWordM = '0;
      testPattM = '0;
      testEnM = '0;
      diffMaxM = '0;
      repeat (4) nextCycle();
      running = 1;
      nextCycle();  // first Idle0 goes out with the release
      rst = 1'b0;
      checkOn = 1;
      idleCycles(20);

      // register map and ack
      checkRead(AdrId);
      for (int i = 0; i < 8; i++) begin
         do adr = $urandom; while (isMapped(adr));
         checkRead(adr);  // unmapped
      end
      for (int i = 0; i < NumRegOps; i++) begin
         sel = $urandom_range(3);
         adr = (sel == 0) ? AdrSpWord : (sel == 1) ? AdrTestPatt :
               (sel == 2) ? AdrTestEn : AdrDiffMax;
         regWrite(adr, WbDatW'($urandom));
         checkRead(adr);
         idleCycles(8);  // lets a special word run out
      end

      // test pattern per link, then special word
      regWrite(AdrTestEn, 16'h0);
      regWrite(AdrTestPatt, WbDatW'($urandom));
      regWrite(AdrTestEn, 16'h1);
      idleCycles(6);
      regWrite(AdrTestEn, 16'h2);
      idleCycles(6);
      regWrite(AdrTestEn, 16'h0);
      idleCycles(8);
      regWrite(AdrSpWord, WbDatW'($urandom));
      idleCycles(10);

      // random stream with triggers and corruptions
      regWrite(AdrDiffMax, WbDatW'($urandom_range(40)));
      noisy = 1;
      idleCycles(StreamLen);
      noisy = 0;
      idleCycles(12);
      checkRead(AdrBadIdleA);
      checkRead(AdrBadIdleB);

      // isolated pairs, B from two cycles early to two late
      for (int i = 0; i < NumPairs; i++) begin
         regWrite(AdrDiffMax, WbDatW'($urandom_range(80)));
         d = int'($urandom_range(4)) - 2;
         injOff[2 * (edgeCnt + 4)] = $urandom_range(63);
         injOff[2 * (edgeCnt + 4 + d) + 1] = $urandom_range(63);
         idleCycles(16);
      end
      idleCycles(12);
      checkRead(AdrBadIdleA);
      checkRead(AdrBadIdleB);

      $display("TB PASSED");
      $finish;
   end

endmodule

/* rtl/mcuTop.sv */
// top level of the two-link coincidence unit
// register file on wishbone, one receiver and transmitter per link, shared matcher
// DeviceId is passed through to the register file

module mcuTop #(
   parameter logic [mcuPkg::WbDatW-1:0] DeviceId = '0
) (
   input  logic                         clk,
   input  logic                         rst,
   input  mcuPkg::wbReq_t               wbIn,
   output mcuPkg::wbRsp_t               wbOut,
   input  logic [mcuPkg::LinkInW-1:0]   linkInA,
   input  logic [mcuPkg::LinkInW-1:0]   linkInB,
   output logic [mcuPkg::LinkOutW-1:0]  linkOutA,
   output logic [mcuPkg::LinkOutW-1:0]  linkOutB
);
   import mcuPkg::*;

   trigEvent_t       trigA, trigB;
   coincAnswer_t     answerA, answerB;
   linkCtrl_t        ctrlA, ctrlB;
   logic [DiffW-1:0] diffMax;
   logic [15:0]      badIdleA, badIdleB;

   mcuRegs #(
      .DeviceId(DeviceId)
   ) regs (
      .clk(clk),
      .rst(rst),
      .wbIn(wbIn),
      .wbOut(wbOut),
      .badIdleA(badIdleA),
      .badIdleB(badIdleB),
      .ctrlA(ctrlA),
      .ctrlB(ctrlB),
      .diffMax(diffMax)
   );

   // link A
   linkRx rxA (.clk(clk), .rst(rst), .linkIn(linkInA), .trig(trigA), .badIdle(badIdleA));
   linkTx txA (.clk(clk), .rst(rst), .ctrl(ctrlA), .answer(answerA), .linkOut(linkOutA));

   // link B
   linkRx rxB (.clk(clk), .rst(rst), .linkIn(linkInB), .trig(trigB), .badIdle(badIdleB));
   linkTx txB (.clk(clk), .rst(rst), .ctrl(ctrlB), .answer(answerB), .linkOut(linkOutB));

   coincMatch match (
      .clk(clk),
      .rst(rst),
      .trigA(trigA),
      .trigB(trigB),
      .diffMax(diffMax),
      .answerA(answerA),
      .answerB(answerB)
   );

endmodule

/* rtl/coincMatch.sv */
// A/B coincidence matcher
// a trigger in the centre stage of one side is checked against all three stages
// of the other side, answer registered three edges after the word was sampled

module coincMatch (
   input  logic                       clk,
   input  logic                       rst,
   input  mcuPkg::trigEvent_t         trigA,
   input  mcuPkg::trigEvent_t         trigB,
   input  logic [mcuPkg::DiffW-1:0]   diffMax,
   output mcuPkg::coincAnswer_t       answerA,
   output mcuPkg::coincAnswer_t       answerB
);
   import mcuPkg::*;

   localparam logic signed [DiffW-1:0] Shift = DiffW'(CycleUnits);  // one clock in offset units

   trigEvent_t [2:0] histA;  // [0] newest, [1] centre, [2] oldest
   trigEvent_t [2:0] histB;

   // verdict for the centre trigger of own against every stage of other
   function automatic coincAnswer_t judge(
      input trigEvent_t [2:0] own,
      input trigEvent_t [2:0] other,
      input logic [DiffW-1:0] lim
   );
      coincAnswer_t            res;
      logic signed [DiffW-1:0] diff;
      logic [DiffW-1:0]        absDiff;
      logic                    hit;
      hit = 1'b0;
      for (int i = 0; i < 3; i++) begin
         diff = DiffW'(signed'(other[i].offset)) - DiffW'(signed'(own[1].offset));
         if (i == 0) diff = diff + Shift;  // other side one cycle later
         if (i == 2) diff = diff - Shift;  // other side one cycle earlier
         absDiff = diff[DiffW-1] ? DiffW'(-diff) : DiffW'(diff);  // at most 95
         if (other[i].trig && absDiff <= lim) hit = 1'b1;
      end
      res.accept = own[1].trig && hit;
      res.reject = own[1].trig && !hit;
      return res;
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         histA   <= '0;
         histB   <= '0;
         answerA <= '0;
         answerB <= '0;
      end else begin
         histA   <= {histA[1:0], trigA};
         histB   <= {histB[1:0], trigB};
         answerA <= judge(histA, histB, diffMax);  // same rule both ways
         answerB <= judge(histB, histA, diffMax);
      end
   end

endmodule

/* rtl/linkTx.sv */
// transmit sequencer of one link
// idles cycle Idle0..Idle3, answers and the special word cut in from set states
// test enable overrides the output with the fixed pattern

module linkTx (
   input  logic                         clk,
   input  logic                         rst,
   input  mcuPkg::linkCtrl_t            ctrl,
   input  mcuPkg::coincAnswer_t         answer,
   output logic [mcuPkg::LinkOutW-1:0]  linkOut
);
   import mcuPkg::*;

   typedef enum logic [3:0] {
      StIdle0,
      StIdle1,
      StIdle2,
      StIdle3,
      StNoCoinc,
      StPrompt,
      StSpecial,
      StSpec1,
      StSpec2,
      StSpec3,
      StSpec4
   } txState_t;

   txState_t            state;
   txState_t            nextState;
   logic [LinkOutW-1:0] code;     // output word of the current state
   logic                ansOk;    // state may take an answer
   logic                spOk;     // state may start a special sequence

   always_comb begin
      nextState = StIdle0;
      code      = KIdle0;
      ansOk     = 1'b0;
      spOk      = 1'b0;
      case (state)
         StIdle0: begin
            code      = KIdle0;
            nextState = StIdle1;
            ansOk     = 1'b1;
            spOk      = 1'b1;
         end
         StIdle1: begin
            code      = KIdle1;
            nextState = StIdle2;
            ansOk     = 1'b1;
            spOk      = 1'b1;
         end
         StIdle2: begin
            code      = KIdle2;
            nextState = StIdle3;
            ansOk     = 1'b1;
            spOk      = 1'b1;
         end
         StIdle3: begin
            code      = KIdle3;
            nextState = StIdle0;  // group wraps
            ansOk     = 1'b1;
            spOk      = 1'b1;
         end
         StNoCoinc: begin
            code = KNoCoinc;
            spOk = 1'b1;  // a new answer here is dropped
         end
         StPrompt: begin
            code = KPromptCoinc;
            spOk = 1'b1;
         end
         StSpecial: begin
            code      = KSpecial;
            nextState = StSpec1;
         end
         StSpec1: begin
            code      = ctrl.spWord[3*LinkOutW +: LinkOutW];  // high nibble first
            nextState = StSpec2;
         end
         StSpec2: begin
            code      = ctrl.spWord[2*LinkOutW +: LinkOutW];
            nextState = StSpec3;
         end
         StSpec3: begin
            code      = ctrl.spWord[LinkOutW +: LinkOutW];
            nextState = StSpec4;
         end
         StSpec4: begin
            code  = ctrl.spWord[0 +: LinkOutW];
            ansOk = 1'b1;  // last nibble can be followed straight away
            spOk  = 1'b1;
         end
         default: nextState = StIdle0;
      endcase
      // priority special, accept, reject
      if (ansOk && answer.reject) nextState = StNoCoinc;
      if (ansOk && answer.accept) nextState = StPrompt;
      if (spOk && ctrl.sendSpecial) nextState = StSpecial;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= StIdle0;
         linkOut <= KIdle3;  // looks like the end of a group
      end else begin
         state   <= nextState;
         linkOut <= ctrl.testEn ? ctrl.testPatt : code;  // sequencer keeps running under test
      end
   end

endmodule

/* rtl/linkRx.sv */
// receive side of one detector link
// turns incoming words into trigger events and checks the idle group sequence
// badIdle counts every sequence fault, two edges after the word is sampled

module linkRx (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [mcuPkg::LinkInW-1:0]  linkIn,
   output mcuPkg::trigEvent_t          trig,
   output logic [15:0]                 badIdle
);
   import mcuPkg::*;

   logic [LinkInW-1:0] curWord;    // word under check, one edge behind linkIn
   logic [LinkInW-1:0] prevWord;   // the word before it
   logic               curValid;   // no check on the first edge out of reset
   logic [11:0]        grpCnt;     // nibbles of the group being received
   logic [15:0]        idleCnt;    // last completed group count
   logic [15:0]        fullCnt;
   logic [3:0]         nib;        // count bits carried by curWord
   logic               isTrig;
   logic               cur0, cur1, cur2, cur3;
   logic               prev0, prev1, prev2;
   logic               seqBad;     // order fault or unknown word
   logic               cntBad;     // group count did not step by one
   logic               seqBadQ;
   logic               cntBadQ;

   assign isTrig = (curWord & TrigMask) != '0;
   assign cur0   = (curWord & IdleMask) == Idle0In;  // mask has bit 7, so never a trigger
   assign cur1   = (curWord & IdleMask) == Idle1In;
   assign cur2   = (curWord & IdleMask) == Idle2In;
   assign cur3   = (curWord & IdleMask) == Idle3In;
   assign prev0  = (prevWord & IdleMask) == Idle0In;
   assign prev1  = (prevWord & IdleMask) == Idle1In;
   assign prev2  = (prevWord & IdleMask) == Idle2In;

   assign nib     = {curWord[5:4], curWord[1:0]};
   assign fullCnt = {nib, grpCnt};  // valid when curWord is Idle3

   always_comb begin
      seqBad = 1'b0;
      cntBad = 1'b0;
      if (curValid && !isTrig) begin
         if (cur0) begin
            seqBad = (prev0 || prev1 || prev2);  // a trigger or junk before Idle0 is fine
         end else if (cur1) begin
            seqBad = !prev0;
         end else if (cur2) begin
            seqBad = !prev1;
         end else if (cur3) begin
            seqBad = !prev2;
            cntBad = fullCnt != idleCnt + 16'd1;  // may add to an order fault
         end else begin
            seqBad = 1'b1;  // neither trigger nor idle
         end
      end
   end

   // trigger path, valid the cycle after sampling
   always_ff @(posedge clk) begin
      trig.offset <= linkIn[OffsetW:1];
      if (rst) begin
         trig.trig <= 1'b0;
      end else begin
         trig.trig <= (linkIn & TrigMask) != '0;
      end
   end

   // group nibbles, checked against idleCnt when Idle3 arrives
   always_ff @(posedge clk) begin
      if (curValid && cur0) grpCnt[3:0]  <= nib;
      if (curValid && cur1) grpCnt[7:4]  <= nib;
      if (curValid && cur2) grpCnt[11:8] <= nib;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         curWord  <= '0;
         prevWord <= '0;
         curValid <= 1'b0;
         idleCnt  <= '0;
         seqBadQ  <= 1'b0;
         cntBadQ  <= 1'b0;
         badIdle  <= '0;
      end else begin
         curWord  <= linkIn;
         prevWord <= curWord;
         curValid <= 1'b1;
         seqBadQ  <= seqBad;
         cntBadQ  <= cntBad;
         badIdle  <= badIdle + 16'(seqBadQ) + 16'(cntBadQ);  // wraps
         if (curValid && cur3) idleCnt <= fullCnt;  // next group counts from here
      end
   end

endmodule

/* rtl/mcuRegs.sv */
// control and monitoring registers behind a wishbone classic slave
// holds the special word, test pattern, test enables and diffMax
// reads back the bad-idle counters of both links

module mcuRegs #(
   parameter logic [mcuPkg::WbDatW-1:0] DeviceId = '0  // returned at AdrId
) (
   input  logic                       clk,
   input  logic                       rst,
   input  mcuPkg::wbReq_t             wbIn,
   output mcuPkg::wbRsp_t             wbOut,
   input  logic [15:0]                badIdleA,
   input  logic [15:0]                badIdleB,
   output mcuPkg::linkCtrl_t          ctrlA,
   output mcuPkg::linkCtrl_t          ctrlB,
   output logic [mcuPkg::DiffW-1:0]   diffMax
);
   import mcuPkg::*;

   logic [4*LinkOutW-1:0] spWord;
   logic [LinkOutW-1:0]   testPatt;
   logic [1:0]            testEn;       // one bit per link
   logic                  ack;
   logic [WbDatW-1:0]     rdQ;          // read data, valid with ack
   logic [WbDatW-1:0]     rdData;
   logic                  access;       // new request this cycle
   logic                  spHit;        // special word written, ack cycle
   logic                  sendSpecial;  // one cycle later

   // a request is taken once, the cycle ack is low
   assign access = wbIn.cyc && wbIn.stb && !ack;

   // read mux, narrow registers zero extended
   always_comb begin
      case (wbIn.adr)
         AdrId:       rdData = DeviceId;
         AdrSpWord:   rdData = WbDatW'(spWord);
         AdrTestPatt: rdData = WbDatW'(testPatt);
         AdrTestEn:   rdData = WbDatW'(testEn);
         AdrDiffMax:  rdData = WbDatW'(diffMax);
         AdrBadIdleA: rdData = WbDatW'(badIdleA);
         AdrBadIdleB: rdData = WbDatW'(badIdleB);
         default:     rdData = '0;  // unmapped
      endcase
   end

   always_ff @(posedge clk) begin
      if (access) begin
         rdQ <= rdData;  // a write also returns the old value, ignored by the master
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ack         <= 1'b0;
         spWord      <= '0;
         testPatt    <= '0;
         testEn      <= '0;
         diffMax     <= '0;
         spHit       <= 1'b0;
         sendSpecial <= 1'b0;
      end else begin
         ack         <= access;  // single cycle, access drops while ack is high
         spHit       <= access && wbIn.we && (wbIn.adr == AdrSpWord);
         sendSpecial <= spHit;   // lands the cycle after ack
         if (access && wbIn.we) begin
            case (wbIn.adr)
               AdrSpWord:   spWord   <= wbIn.dat[4*LinkOutW-1:0];
               AdrTestPatt: testPatt <= wbIn.dat[LinkOutW-1:0];
               AdrTestEn:   testEn   <= wbIn.dat[1:0];
               AdrDiffMax:  diffMax  <= wbIn.dat[DiffW-1:0];
               default: ;  // read-only or unmapped, write dropped
            endcase
         end
      end
   end

   assign wbOut.ack = ack;
   assign wbOut.dat = rdQ;

   // both links share word, pulse and pattern
   // only the enable is split
   assign ctrlA.spWord      = spWord;
   assign ctrlA.sendSpecial = sendSpecial;
   assign ctrlA.testPatt    = testPatt;
   assign ctrlA.testEn      = testEn[0];

   assign ctrlB.spWord      = spWord;
   assign ctrlB.sendSpecial = sendSpecial;
   assign ctrlB.testPatt    = testPatt;
   assign ctrlB.testEn      = testEn[1];

endmodule

/* rtl/mcuPkg.sv */
// shared definitions for the cut-down master coincidence unit
// link word codes, register map, bus widths and the structs passed between blocks
// every design file imports this package

package mcuPkg;

   // link word widths
   localparam int LinkInW  = 8;  // detector -> mcu
   localparam int LinkOutW = 4;  // mcu -> detector

   // fine timing
   localparam int OffsetW    = 6;   // signed trigger offset inside one clock
   localparam int CycleUnits = 32;  // offset units per clock period
   localparam int DiffW      = 8;   // offset difference and its limit

   // wishbone bus
   localparam int WbAdrW = 16;
   localparam int WbDatW = 16;

   // incoming word classes
   localparam logic [LinkInW-1:0] TrigMask = 8'h80;  // bit 7 marks a trigger
   localparam logic [LinkInW-1:0] IdleMask = 8'hCC;  // selects idle type bits
   localparam logic [LinkInW-1:0] Idle0In  = 8'h40;  // carries count[3:0]
   localparam logic [LinkInW-1:0] Idle1In  = 8'h44;
   localparam logic [LinkInW-1:0] Idle2In  = 8'h48;
   localparam logic [LinkInW-1:0] Idle3In  = 8'h4C;  // carries count[15:12]

   // outgoing codes
   localparam logic [LinkOutW-1:0] KIdle0       = 4'h7;
   localparam logic [LinkOutW-1:0] KIdle1       = 4'hB;
   localparam logic [LinkOutW-1:0] KIdle2       = 4'hD;
   localparam logic [LinkOutW-1:0] KIdle3       = 4'hE;
   localparam logic [LinkOutW-1:0] KNoCoinc     = 4'h9;  // reject
   localparam logic [LinkOutW-1:0] KPromptCoinc = 4'h3;  // accept
   localparam logic [LinkOutW-1:0] KSpecial     = 4'hC;  // then four nibbles

   // register map
   localparam logic [WbAdrW-1:0] AdrId       = 16'h0000;  // read only
   localparam logic [WbAdrW-1:0] AdrSpWord   = 16'h0002;  // write also fires the word
   localparam logic [WbAdrW-1:0] AdrTestPatt = 16'h0003;
   localparam logic [WbAdrW-1:0] AdrTestEn   = 16'h0004;  // bit 0 link A, bit 1 link B
   localparam logic [WbAdrW-1:0] AdrDiffMax  = 16'h0005;
   localparam logic [WbAdrW-1:0] AdrBadIdleA = 16'h0010;  // read only
   localparam logic [WbAdrW-1:0] AdrBadIdleB = 16'h0011;  // read only

   // one sampled trigger from a link
   typedef struct packed {
      logic                      trig;
      logic signed [OffsetW-1:0] offset;  // only meaningful with trig
   } trigEvent_t;

   // matcher verdict for one link, at most one flag set, one cycle long
   typedef struct packed {
      logic accept;
      logic reject;
   } coincAnswer_t;

   // per-link transmit control
   typedef struct packed {
      logic [4*LinkOutW-1:0] spWord;       // sent high nibble first
      logic                  sendSpecial;  // single-cycle request
      logic [LinkOutW-1:0]   testPatt;
      logic                  testEn;       // replaces the link output
   } linkCtrl_t;

   // wishbone classic request, master -> slave
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [WbAdrW-1:0] adr;
      logic [WbDatW-1:0] dat;
   } wbReq_t;

   // wishbone classic response, slave -> master
   typedef struct packed {
      logic              ack;
      logic [WbDatW-1:0] dat;
   } wbRsp_t;

endpackage
